/* rob_pkg.sv */
// rob_pkg
// shared widths, types and the retire-select state encoding for the
// two-wide reorder buffer

`default_nettype none

package rob_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // tag width fixed at 5, enough for up to 32 entries
  parameter int TAG_W    = 5;
  parameter int REG_W    = 5;
  parameter int VALUE_W  = 64;
  parameter int INSTR_W  = 32;
  // credit count spans 0..32 so one extra bit
  parameter int CREDIT_W = 6;

  // default depth, top level may override with any power of two 4..32
  parameter int ROB_ENTRIES = 32;

  //////////////////////////////
  // types
  //////////////////////////////

  // entry index, handed out as the dispatch tag
  typedef logic [TAG_W-1:0]    rob_tag_t;
  // architectural destination register
  typedef logic [REG_W-1:0]    reg_idx_t;
  // result value written on completion
  typedef logic [VALUE_W-1:0]  value_t;
  // raw instruction word
  typedef logic [INSTR_W-1:0]  instr_t;
  // credits returned to the dispatcher
  typedef logic [CREDIT_W-1:0] credit_t;

  // how many entries retired on the last edge
  typedef enum logic [1:0] {
    RETIRE_IDLE = 2'd0,
    RETIRE_ONE  = 2'd1,
    RETIRE_TWO  = 2'd2
  } retire_state_t;

endpackage : rob_pkg

`default_nettype wire

/* rob_entry.sv */
// rob_entry
// one reorder buffer slot holding the instruction, destination register,
// result and the valid and complete flags
// loaded on dispatch, filled on completion and emptied on retire

`default_nettype none

module rob_entry (
  input  wire logic              clock,
  input  wire logic              reset,
  // dispatch side
  input  wire logic              dispatch_write,
  input  wire rob_pkg::instr_t   dispatch_instruction,
  input  wire rob_pkg::reg_idx_t dispatch_register,
  // completion side
  input  wire logic              complete_write,
  input  wire rob_pkg::value_t   complete_value,
  // retire side
  input  wire logic              retire_clear,
  // registered entry state
  output logic                   valid,
  output logic                   complete,
  output rob_pkg::instr_t        instruction,
  output rob_pkg::reg_idx_t      register,
  output rob_pkg::value_t        value
);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      valid    <= 1'b0;
      complete <= 1'b0;
    end
    else
    begin
      // retire empties the slot
      if (retire_clear)
      begin
        valid    <= 1'b0;
        complete <= 1'b0;
      end
      // a new instruction starts out incomplete
      if (dispatch_write)
      begin
        valid    <= 1'b1;
        complete <= 1'b0;
      end
      if (complete_write)
        complete <= 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (dispatch_write)
    begin
      instruction <= dispatch_instruction;
      register    <= dispatch_register;
      // no result until the completion arrives
      value       <= '0;
    end
    if (complete_write)
      value <= complete_value;
  end

endmodule

`default_nettype wire

/* rob_ptr_ctrl.sv */
// rob_ptr_ctrl
// head and tail pointers of the circular entry array, the two
// dispatch tags, and the registered credit return

`default_nettype none

module rob_ptr_ctrl #(
  parameter int ROB_ENTRIES = rob_pkg::ROB_ENTRIES
) (
  input  wire logic              clock,
  input  wire logic              reset,
  // dispatch slots, slot 1 only when slot 0
  input  wire logic              dispatch_valid0,
  input  wire logic              dispatch_valid1,
  // entries leaving at this edge, 0..2
  input  wire logic [1:0]        retire_count,
  output rob_pkg::rob_tag_t      head,
  output rob_pkg::rob_tag_t      tail,
  output rob_pkg::rob_tag_t      dispatch_tag0,
  output rob_pkg::rob_tag_t      dispatch_tag1,
  output rob_pkg::credit_t       credit_return
);

  import rob_pkg::*;

  // wrap mask, depth is a power of two
  localparam rob_tag_t PTR_MASK = rob_tag_t'(ROB_ENTRIES - 1);

  logic [1:0] dispatch_count;
  rob_tag_t   tail_next;
  rob_tag_t   head_next;

  //////////////////////////////
  // dispatch tags
  //////////////////////////////

  // slot 0 lands on the tail, slot 1 right behind it
  always_comb
  begin
    dispatch_tag0 = tail;
    dispatch_tag1 = (tail + rob_tag_t'(1)) & PTR_MASK;
  end

  //////////////////////////////
  // next pointers
  //////////////////////////////

  always_comb
  begin
    // number of instructions entering this cycle
    dispatch_count = {1'b0, dispatch_valid0} + {1'b0, dispatch_valid1};
    // tail moves by dispatch count, head by retire count
    tail_next = (tail + rob_tag_t'(dispatch_count)) & PTR_MASK;
    head_next = (head + rob_tag_t'(retire_count)) & PTR_MASK;
  end

  //////////////////////////////
  // pointer registers
  //////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head <= '0;
      tail <= '0;
    end
    else
    begin
      head <= head_next;
      tail <= tail_next;
    end
  end

  //////////////////////////////
  // credit return
  //////////////////////////////

  // one credit per retired entry
  // registered so it lines up with the retire outputs
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      credit_return <= '0;
    end
    else
    begin
      credit_return <= credit_t'(retire_count);
    end
  end

endmodule : rob_ptr_ctrl

`default_nettype wire

/* rob_retire_sel.sv */
// rob_retire_sel
// looks at the head and the slot behind it, picks up to two in-order
// retirements and registers their fields onto the retire outputs

`default_nettype none

module rob_retire_sel #(
  parameter int ROB_ENTRIES = rob_pkg::ROB_ENTRIES
) (
  input  wire logic                                      clock,
  input  wire logic                                      reset,
  input  wire rob_pkg::rob_tag_t                         head,
  // per-entry state, flattened by entry index
  input  wire logic [ROB_ENTRIES-1:0]                    entry_valid,
  input  wire logic [ROB_ENTRIES-1:0]                    entry_complete,
  input  wire logic [ROB_ENTRIES*rob_pkg::REG_W-1:0]     entry_register,
  input  wire logic [ROB_ENTRIES*rob_pkg::VALUE_W-1:0]   entry_value,
  input  wire logic [ROB_ENTRIES*rob_pkg::INSTR_W-1:0]   entry_instruction,
  // entries clearing at this edge
  output logic [1:0]                                     retire_count,
  output logic                                           retire_valid0,
  output logic                                           retire_valid1,
  output rob_pkg::reg_idx_t                              retire_register0,
  output rob_pkg::reg_idx_t                              retire_register1,
  output rob_pkg::value_t                                retire_value0,
  output rob_pkg::value_t                                retire_value1,
  output rob_pkg::instr_t                                retire_instruction0,
  output rob_pkg::instr_t                                retire_instruction1
);

  import rob_pkg::*;

  localparam rob_tag_t PTR_MASK = rob_tag_t'(ROB_ENTRIES - 1);

  rob_tag_t      head_plus_one;
  logic          head_ready;
  logic          next_ready;
  retire_state_t retire_state;

  //////////////////////////////
  // selection
  //////////////////////////////

  always_comb
  begin
    head_plus_one = (head + rob_tag_t'(1)) & PTR_MASK;
    head_ready    = entry_valid[head] && entry_complete[head];
    next_ready    = entry_valid[head_plus_one] && entry_complete[head_plus_one];
    // second slot only behind a ready head, keeps program order
    if (!head_ready)
      retire_count = 2'd0;
    else if (next_ready)
      retire_count = 2'd2;
    else
      retire_count = 2'd1;
  end

  // retire count of the last edge, drives the output valids
  always_ff @(posedge clock)
  begin
    if (reset)
      retire_state <= RETIRE_IDLE;
    else
      retire_state <= retire_state_t'(retire_count);
  end

  always_comb
  begin
    retire_valid0 = (retire_state != RETIRE_IDLE);
    retire_valid1 = (retire_state == RETIRE_TWO);
  end

  //////////////////////////////
  // retire payload
  //////////////////////////////

  // captured at the same edge the entries clear
  always_ff @(posedge clock)
  begin
    if (retire_count != 2'd0)
    begin
      retire_register0    <= entry_register[head*REG_W +: REG_W];
      retire_value0       <= entry_value[head*VALUE_W +: VALUE_W];
      retire_instruction0 <= entry_instruction[head*INSTR_W +: INSTR_W];
      // slot 1 payload is only meaningful with retire_valid1
      retire_register1    <= entry_register[head_plus_one*REG_W +: REG_W];
      retire_value1       <= entry_value[head_plus_one*VALUE_W +: VALUE_W];
      retire_instruction1 <= entry_instruction[head_plus_one*INSTR_W +: INSTR_W];
    end
  end

endmodule : rob_retire_sel

`default_nettype wire

/* rob.sv */
// rob
// two-wide reorder buffer built as a circular array of entries with tag
// decode for dispatch and completion, in-order retire of up to two per
// cycle and a credit return toward the dispatcher

`default_nettype none

module rob #(
  parameter int ROB_ENTRIES = rob_pkg::ROB_ENTRIES
) (
  input  wire logic              clock,
  input  wire logic              reset,
  // dispatch slots
  input  wire logic              dispatch_valid0,
  input  wire rob_pkg::instr_t   dispatch_instruction0,
  input  wire rob_pkg::reg_idx_t dispatch_register0,
  input  wire logic              dispatch_valid1,
  input  wire rob_pkg::instr_t   dispatch_instruction1,
  input  wire rob_pkg::reg_idx_t dispatch_register1,
  // completion ports
  input  wire logic              complete_valid0,
  input  wire rob_pkg::rob_tag_t complete_tag0,
  input  wire rob_pkg::value_t   complete_value0,
  input  wire logic              complete_valid1,
  input  wire rob_pkg::rob_tag_t complete_tag1,
  input  wire rob_pkg::value_t   complete_value1,
  // tags handed back to the dispatcher
  output rob_pkg::rob_tag_t      dispatch_tag0,
  output rob_pkg::rob_tag_t      dispatch_tag1,
  // retire slots
  output logic                   retire_valid0,
  output rob_pkg::reg_idx_t      retire_register0,
  output rob_pkg::value_t        retire_value0,
  output rob_pkg::instr_t        retire_instruction0,
  output logic                   retire_valid1,
  output rob_pkg::reg_idx_t      retire_register1,
  output rob_pkg::value_t        retire_value1,
  output rob_pkg::instr_t        retire_instruction1,
  output rob_pkg::credit_t       credit_return
);

  import rob_pkg::*;

  localparam rob_tag_t PTR_MASK = rob_tag_t'(ROB_ENTRIES - 1);

  rob_tag_t   head;
  rob_tag_t   head_plus_one;
  logic [1:0] retire_count;

  // entry state flattened for the retire selector
  logic [ROB_ENTRIES-1:0]         entry_valid;
  logic [ROB_ENTRIES-1:0]         entry_complete;
  logic [ROB_ENTRIES*REG_W-1:0]   entry_register;
  logic [ROB_ENTRIES*VALUE_W-1:0] entry_value;
  logic [ROB_ENTRIES*INSTR_W-1:0] entry_instruction;

  //////////////////////////////
  // pointers and credits
  //////////////////////////////

  rob_ptr_ctrl #(
    .ROB_ENTRIES (ROB_ENTRIES)
  ) ptr_ctrl_i (
    .clock           (clock),
    .reset           (reset),
    .dispatch_valid0 (dispatch_valid0),
    .dispatch_valid1 (dispatch_valid1),
    .retire_count    (retire_count),
    .head            (head),
    .tail            (),
    .dispatch_tag0   (dispatch_tag0),
    .dispatch_tag1   (dispatch_tag1),
    .credit_return   (credit_return)
  );

  // second retiring slot used by the clear decode
  always_comb
  begin
    head_plus_one = (head + rob_tag_t'(1)) & PTR_MASK;
  end

  //////////////////////////////
  // entry array
  //////////////////////////////

  for (genvar i = 0; i < ROB_ENTRIES; i++)
  begin : g_entry
    localparam rob_tag_t IDX = rob_tag_t'(i);

    logic disp_hit0;
    logic disp_hit1;
    logic cmp_hit0;
    logic cmp_hit1;
    logic clear_hit;

    always_comb
    begin
      // each dispatch slot hits at most one entry
      disp_hit0 = dispatch_valid0 && (dispatch_tag0 == IDX);
      disp_hit1 = dispatch_valid1 && (dispatch_tag1 == IDX);
      // completion ports never share a tag
      cmp_hit0  = complete_valid0 && (complete_tag0 == IDX);
      cmp_hit1  = complete_valid1 && (complete_tag1 == IDX);
      // head clears on any retire and head plus one only on a pair
      clear_hit = ((retire_count != 2'd0) && (head == IDX)) ||
                  ((retire_count == 2'd2) && (head_plus_one == IDX));
    end

    rob_entry entry_i (
      .clock                (clock),
      .reset                (reset),
      .dispatch_write       (disp_hit0 || disp_hit1),
      .dispatch_instruction (disp_hit1 ? dispatch_instruction1 : dispatch_instruction0),
      .dispatch_register    (disp_hit1 ? dispatch_register1 : dispatch_register0),
      .complete_write       (cmp_hit0 || cmp_hit1),
      .complete_value       (cmp_hit1 ? complete_value1 : complete_value0),
      .retire_clear         (clear_hit),
      .valid                (entry_valid[i]),
      .complete             (entry_complete[i]),
      .instruction          (entry_instruction[i*INSTR_W +: INSTR_W]),
      .register             (entry_register[i*REG_W +: REG_W]),
      .value                (entry_value[i*VALUE_W +: VALUE_W])
    );
  end

  //////////////////////////////
  // retire
  //////////////////////////////

  rob_retire_sel #(
    .ROB_ENTRIES (ROB_ENTRIES)
  ) retire_sel_i (
    .clock               (clock),
    .reset               (reset),
    .head                (head),
    .entry_valid         (entry_valid),
    .entry_complete      (entry_complete),
    .entry_register      (entry_register),
    .entry_value         (entry_value),
    .entry_instruction   (entry_instruction),
    .retire_count        (retire_count),
    .retire_valid0       (retire_valid0),
    .retire_valid1       (retire_valid1),
    .retire_register0    (retire_register0),
    .retire_register1    (retire_register1),
    .retire_value0       (retire_value0),
    .retire_value1       (retire_value1),
    .retire_instruction0 (retire_instruction0),
    .retire_instruction1 (retire_instruction1)
  );

endmodule : rob

`default_nettype wire

/* rob_assert.sv */
// rob_assert
// concurrent checks on dispatch credits, retire ordering and the
// credit return, bound into the rob top level

`default_nettype none

module rob_assert #(
  parameter int ROB_ENTRIES = rob_pkg::ROB_ENTRIES
) (
  input  wire logic             clock,
  input  wire logic             reset,
  input  wire logic             dispatch_valid0,
  input  wire logic             dispatch_valid1,
  input  wire logic             retire_valid0,
  input  wire logic             retire_valid1,
  input  wire rob_pkg::credit_t credit_return
);

  import rob_pkg::*;

  // credits held by the dispatcher, not counting this cycle's return
  credit_t credits;
  credit_t dispatch_count;
  credit_t retire_seen;

  always_comb
  begin
    dispatch_count = credit_t'(dispatch_valid0) + credit_t'(dispatch_valid1);
    retire_seen    = credit_t'(retire_valid0) + credit_t'(retire_valid1);
  end

  // one credit per entry out of reset
  always_ff @(posedge clock)
  begin
    if (reset)
      credits <= credit_t'(ROB_ENTRIES);
    else
      credits <= credits + credit_return - dispatch_count;
  end

  //////////////////////////////
  // properties
  //////////////////////////////

  // a returned credit may be spent in the cycle it shows up
  credit_limit: assert property (@(posedge clock) disable iff (reset)
    dispatch_count <= credits + credit_return)
    else $error("dispatch count exceeds the credits held");

  // second retire slot never without the first
  retire_order: assert property (@(posedge clock) disable iff (reset)
    retire_valid1 |-> retire_valid0)
    else $error("retire_valid1 seen without retire_valid0");

  credit_match: assert property (@(posedge clock) disable iff (reset)
    credit_return == retire_seen)
    else $error("credit_return differs from the number of retire valids");

endmodule : rob_assert

bind rob rob_assert #(
  .ROB_ENTRIES (ROB_ENTRIES)
) assert_i (
  .clock           (clock),
  .reset           (reset),
  .dispatch_valid0 (dispatch_valid0),
  .dispatch_valid1 (dispatch_valid1),
  .retire_valid0   (retire_valid0),
  .retire_valid1   (retire_valid1),
  .credit_return   (credit_return)
);

`default_nettype wire

/* rob_tb.sv */
// rob_tb
// table-driven testbench for the reorder buffer checked against a
// queue model of dispatch, completion and in-order retirement

`default_nettype none

module rob_tb;

  import rob_pkg::*;

  localparam int ENTRIES = 32;

  // one model entry per dispatched instruction with the oldest first
  typedef struct packed {
    rob_tag_t tag;
    reg_idx_t rd;
    instr_t   instr;
    value_t   value;
    logic     done;
  } model_entry_t;

  logic     clock = 1'b0;
  logic     reset;
  logic     dispatch_valid0, dispatch_valid1, complete_valid0, complete_valid1;
  instr_t   dispatch_instruction0, dispatch_instruction1;
  reg_idx_t dispatch_register0, dispatch_register1;
  rob_tag_t complete_tag0, complete_tag1, dispatch_tag0, dispatch_tag1;
  value_t   complete_value0, complete_value1;
  logic     retire_valid0, retire_valid1;
  reg_idx_t retire_register0, retire_register1;
  value_t   retire_value0, retire_value1;
  instr_t   retire_instruction0, retire_instruction1;
  credit_t  credit_return;

  model_entry_t model_q[$];
  // tags dispatched but still without a result
  rob_tag_t     pending[$];
  // retirements expected from the coming edge
  model_entry_t expected[2];
  int           exp_count = 0;
  rob_tag_t     next_tag = '0;
  int           credits = ENTRIES;
  int           seed = 61;
  int           cycles = 0;
  int           cycle_limit = 0;
  // stimulus table with one row per cycle
  int           row_disp[$];
  int           row_ncomp[$];
  int           row_idx0[$];
  int           row_idx1[$];

  rob #(
    .ROB_ENTRIES (ENTRIES)
  ) dut_i (.*);

  always #10 clock = ~clock;

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want)
      fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, want));
  endtask

  task automatic check_register(input string name, input reg_idx_t got, input reg_idx_t want);
    if (got !== want)
      fail_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, want));
  endtask

  task automatic check_value(input string name, input value_t got, input value_t want);
    if (got !== want)
      fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want));
  endtask

  task automatic check_instruction(input string name, input instr_t got, input instr_t want);
    if (got !== want)
      fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want));
  endtask

  task automatic check_credit(input string name, input credit_t got, input credit_t want);
    if (got !== want)
      fail_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, want));
  endtask

  task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t want);
    if (got !== want)
      fail_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, want));
  endtask

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  task automatic add_row(input int disp, input int ncomp, input int idx0, input int idx1);
    row_disp.push_back(disp);
    row_ncomp.push_back(ncomp);
    row_idx0.push_back(idx0);
    row_idx1.push_back(idx1);
  endtask

  // columns are dispatch count, completions, pending index 0 and pending index 1
  task automatic build_table();
    // tags 2, 1 and 0 complete in that order
    add_row(2, 0, 0, 0);
    add_row(1, 0, 0, 0);
    add_row(0, 1, 2, 0);
    add_row(0, 0, 0, 0);
    add_row(0, 1, 1, 0);
    add_row(0, 0, 0, 0);
    add_row(0, 1, 0, 0);
    repeat (3) add_row(0, 0, 0, 0);
    // adjacent pair completed together
    add_row(2, 0, 0, 0);
    add_row(0, 2, 0, 0);
    repeat (2) add_row(0, 0, 0, 0);
    // mixed traffic
    add_row(2, 1, 0, 0);
    add_row(1, 2, 1, 0);
    add_row(2, 0, 0, 0);
    add_row(0, 2, 2, 0);
    add_row(1, 1, 3, 0);
    repeat (2) add_row(0, 2, 0, 0);
    repeat (5) add_row(0, 0, 0, 0);
    // spend every credit across the wrap and then complete in reverse pairs
    repeat (ENTRIES / 2) add_row(2, 0, 0, 0);
    repeat (ENTRIES / 2) add_row(0, 2, 1, 0);
    repeat (3) add_row(0, 0, 0, 0);
  endtask

  //////////////////////////////
  // one cycle
  //////////////////////////////

  task automatic run_cycle(input int disp, input int ncomp, input int idx0, input int idx1);
    int           pick;
    int           n;
    value_t       val;
    model_entry_t ent;
    // outputs of the last edge
    check_flag("retire_valid0", retire_valid0, exp_count > 0);
    check_flag("retire_valid1", retire_valid1, exp_count == 2);
    check_credit("credit_return", credit_return, credit_t'(exp_count));
    for (int s = 0; s < exp_count; s++)
    begin
      check_register($sformatf("retire_register%0d", s),
                     (s == 0) ? retire_register0 : retire_register1, expected[s].rd);
      check_value($sformatf("retire_value%0d", s),
                  (s == 0) ? retire_value0 : retire_value1, expected[s].value);
      check_instruction($sformatf("retire_instruction%0d", s),
                        (s == 0) ? retire_instruction0 : retire_instruction1, expected[s].instr);
    end
    credits += int'(credit_return);
    check_tag("dispatch_tag0", dispatch_tag0, next_tag);
    check_tag("dispatch_tag1", dispatch_tag1, rob_tag_t'((next_tag + 1) % ENTRIES));
    // in-order retire from the head decided on the state before this edge
    exp_count = 0;
    while (exp_count < 2 && model_q.size() > 0 && model_q[0].done)
    begin
      expected[exp_count] = model_q.pop_front();
      exp_count++;
    end
    // each completion index is taken from what is still pending
    complete_valid0 = 1'b0;
    complete_valid1 = 1'b0;
    n = (ncomp < pending.size()) ? ncomp : pending.size();
    for (int c = 0; c < n; c++)
    begin
      pick = ((c == 0) ? idx0 : idx1) % pending.size();
      val  = {$random(seed), $random(seed)};
      if (c == 0)
      begin
        complete_valid0 = 1'b1;
        complete_tag0   = pending[pick];
        complete_value0 = val;
      end
      else
      begin
        complete_valid1 = 1'b1;
        complete_tag1   = pending[pick];
        complete_value1 = val;
      end
      foreach (model_q[i])
        if (model_q[i].tag == pending[pick])
        begin
          model_q[i].done  = 1'b1;
          model_q[i].value = val;
        end
      pending.delete(pick);
    end
    // dispatch only on held credits
    n = (disp < credits) ? disp : credits;
    dispatch_valid0 = (n > 0);
    dispatch_valid1 = (n > 1);
    for (int d = 0; d < n; d++)
    begin
      ent.tag   = next_tag;
      ent.rd    = reg_idx_t'($random(seed));
      ent.instr = instr_t'($random(seed));
      ent.value = '0;
      ent.done  = 1'b0;
      if (d == 0)
      begin
        dispatch_instruction0 = ent.instr;
        dispatch_register0    = ent.rd;
      end
      else
      begin
        dispatch_instruction1 = ent.instr;
        dispatch_register1    = ent.rd;
      end
      model_q.push_back(ent);
      pending.push_back(next_tag);
      next_tag = rob_tag_t'((next_tag + 1) % ENTRIES);
      credits--;
    end
    @(posedge clock);
    #2;
  endtask

  // run limit from the table length
  always @(posedge clock)
  begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
      fail_run("timeout, the run went past its cycle limit");
  end

  initial
  begin
    reset = 1'b1;
    {dispatch_valid0, dispatch_valid1, complete_valid0, complete_valid1} = 4'b0;
    {dispatch_instruction0, dispatch_instruction1} = '0;
    {dispatch_register0, dispatch_register1} = '0;
    {complete_tag0, complete_tag1} = '0;
    {complete_value0, complete_value1} = '0;
    build_table();
    cycle_limit = 8 + row_disp.size() + 64;
    repeat (8) @(posedge clock);
    #2;
    reset = 1'b0;
    for (int r = 0; r < row_disp.size(); r++)
      run_cycle(row_disp[r], row_ncomp[r], row_idx0[r], row_idx1[r]);
    // drain whatever is still in flight
    while (model_q.size() > 0 || exp_count > 0)
      run_cycle(0, 2, 0, 0);
    // an empty buffer returns no further retirements or credits
    repeat (2) run_cycle(0, 0, 0, 0);
    $display("NO ERRORS");
    $finish;
  end

endmodule : rob_tb

`default_nettype wire

/* rob.f */
rob_pkg.sv
rob_entry.sv
rob_ptr_ctrl.sv
rob_retire_sel.sv
rob.sv
rob_assert.sv
rob_tb.sv

/* run_rob.sh */
#!/usr/bin/env bash
# build and run the reorder buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f rob.f --top-module rob_tb -o rob_sim

# the simulation may stop early, the log decides the result
./obj_dir/rob_sim 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "NO ERRORS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi

echo "simulation passed"
